//--- hw/video_pkg.sv
// Screen timing constants and pixel, palette and RAM entry types for the video blocks
`default_nettype none

package video_pkg;

    // Horizontal timing, in pixels
    localparam int h_total   = 96;
    localparam int h_visible = 64;
    localparam int hs_start  = 72;
    localparam int hs_len    = 8;

    // Vertical timing, in lines
    localparam int v_total   = 80;
    localparam int v_visible = 64;
    localparam int vs_start  = 70;
    localparam int vs_len    = 3;

    // Clocks from a counter value to its color at the outputs
    localparam int pipe_latency = 3;

    // One layer pixel; prio is only driven by the tile layer
    typedef struct packed {
        logic       prio;
        logic [1:0] bank;
        logic [1:0] color;
    } layer_pxl_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [8:0] rsv;
        logic       prio;
        logic [1:0] bank;
        logic [3:0] code;
    } tile_entry_t;

    typedef struct packed {
        logic [1:0] bank;
        logic [1:0] shape;
        logic [5:0] y;
        logic [5:0] x;
    } obj_entry_t;

endpackage

`default_nettype wire

//--- hw/cpu_bus_pkg.sv
// CPU request and PROM download types, plus the address map of both layers
`default_nettype none

package cpu_bus_pkg;

    typedef struct packed {
        logic [6:0]  addr;
        logic [15:0] wdata;
        logic        we;
    } cpu_req_t;

    typedef struct packed {
        logic [10:0] addr;
        logic [7:0]  data;
        logic        en;
    } prog_t;

    // Tile side: map entries first, scroll register right after
    localparam int         map_entries = 64;
    localparam logic [6:0] scroll_addr = 7'd64;

    // Object side
    localparam int obj_entries = 4;

    // PROM regions, taken from prog addr bits 10 to 8
    localparam logic [2:0] region_red   = 3'd0;
    localparam logic [2:0] region_green = 3'd1;
    localparam logic [2:0] region_blue  = 3'd2;
    localparam logic [2:0] region_tile  = 3'd3;
    localparam logic [2:0] region_obj   = 3'd4;

endpackage

`default_nettype wire

//--- hw/cpu_ram.sv
// Single-port RAM that each layer instantiates to share one port between video fetches and CPU
`timescale 1ns/10ps
`default_nettype none

module cpu_ram #(
    parameter type entry_t = logic [15:0],
    parameter int  depth   = 64
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // Video fetch side
    input  logic                       vid_rd,
    input  logic [$clog2(depth)-1:0]   vid_addr,
    output entry_t                     vid_data,

    // CPU side
    input  cpu_bus_pkg::cpu_req_t      req,
    input  logic                       valid,
    output logic                       ready,
    output entry_t                     rdata,
    output logic                       rvalid
);

    localparam int aw = $clog2(depth);

    entry_t          mem [depth];
    entry_t          rd_q;
    logic            cpu_go;
    logic [aw-1:0]   rd_addr;

    // CPU waits whenever video owns the port
    assign ready   = !vid_rd;
    assign cpu_go  = valid && ready;
    assign rd_addr = vid_rd ? vid_addr : req.addr[aw-1:0];

    always_ff @(posedge clk) begin
        if (cpu_go && req.we) begin
            mem[req.addr[aw-1:0]] <= entry_t'(req.wdata);
        end
        rd_q <= mem[rd_addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= cpu_go && !req.we;
        end
    end

    assign vid_data = rd_q;
    assign rdata    = rd_q;

    // Stalled requests must be held by the CPU
    assert property (@(posedge clk) disable iff (!rst_n)
        valid && !ready |=> valid && $stable(req));

endmodule

`default_nettype wire

//--- hw/video_timer.sv
// Pixel and line counters with blanking, sync and the blanking delay matched to the layers
`timescale 1ns/10ps
`default_nettype none

module video_timer (
    input  logic       clk,
    input  logic       rst_n,
    output logic [6:0] hdump,
    output logic [6:0] vdump,
    output logic       lhbl,
    output logic       lvbl,
    output logic       hs,
    output logic       vs,
    output logic       lhbl_d2,
    output logic       lvbl_d2
);

    // Blanking delay stages ahead of the mixer
    logic [video_pkg::pipe_latency-2:0] hbl_sr;
    logic [video_pkg::pipe_latency-2:0] vbl_sr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= 7'd0;
            vdump <= 7'd0;
        end else if (hdump == 7'(video_pkg::h_total - 1)) begin
            hdump <= 7'd0;
            if (vdump == 7'(video_pkg::v_total - 1)) begin
                vdump <= 7'd0;
            end else begin
                vdump <= vdump + 7'd1;
            end
        end else begin
            hdump <= hdump + 7'd1;
        end
    end

    assign lhbl = hdump < video_pkg::h_visible;
    assign lvbl = vdump < video_pkg::v_visible;

    // Active-low sync windows
    assign hs = !(hdump >= video_pkg::hs_start &&
                  hdump <  video_pkg::hs_start + video_pkg::hs_len);
    assign vs = !(vdump >= video_pkg::vs_start &&
                  vdump <  video_pkg::vs_start + video_pkg::vs_len);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hbl_sr <= '0;
            vbl_sr <= '0;
        end else begin
            hbl_sr <= {hbl_sr[$high(hbl_sr)-1:0], lhbl};
            vbl_sr <= {vbl_sr[$high(vbl_sr)-1:0], lvbl};
        end
    end

    assign lhbl_d2 = hbl_sr[$high(hbl_sr)];
    assign lvbl_d2 = vbl_sr[$high(vbl_sr)];

endmodule

`default_nettype wire

//--- hw/tile_layer.sv
// Scrolling tile layer: map RAM, scroll register, pattern PROM and pixel shifter
`timescale 1ns/10ps
`default_nettype none

module tile_layer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [6:0]              hdump,
    input  logic [6:0]              vdump,
    input  cpu_bus_pkg::cpu_req_t   req,
    input  logic                    valid,
    output logic                    ready,
    output logic [15:0]             rdata,
    output logic                    rvalid,
    input  cpu_bus_pkg::prog_t      prog,
    input  logic                    enable,
    output video_pkg::layer_pxl_t   pxl
);

    logic [7:0]             pat_rom [256];
    logic [5:0]             scroll;
    logic                   is_scroll;
    logic                   map_valid;
    logic                   map_ready;
    logic [15:0]            map_rdata;
    logic                   map_rvalid;
    logic                   scr_rvalid;
    logic [6:0]             hf;
    logic [6:0]             vf;
    logic [5:0]             sx;
    logic [5:0]             sx_f;
    logic                   fetch;
    logic                   ld_q;
    video_pkg::tile_entry_t ent;
    logic [15:0]            pat_row;
    logic [15:0]            shift;
    logic [1:0]             cur_bank;
    logic                   cur_prio;

    // Scroll register is handled here, so its accesses never stall
    assign is_scroll = req.addr == cpu_bus_pkg::scroll_addr;
    assign map_valid = valid && !is_scroll;
    assign ready     = is_scroll || map_ready;
    assign rvalid    = scr_rvalid || map_rvalid;
    assign rdata     = scr_rvalid ? {10'd0, scroll} : map_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scroll     <= 6'd0;
            scr_rvalid <= 1'b0;
            ld_q       <= 1'b0;
        end else begin
            if (valid && is_scroll && req.we) begin
                scroll <= req.wdata[5:0];
            end
            scr_rvalid <= valid && is_scroll && !req.we;
            ld_q       <= fetch;
        end
    end

    always_ff @(posedge clk) begin
        if (prog.en && prog.addr[10:8] == cpu_bus_pkg::region_tile) begin
            pat_rom[prog.addr[7:0]] <= prog.data;
        end
    end

    // Look one pixel ahead, wrapping into the next line at the end of hblank
    always_comb begin
        hf = hdump + 7'd1;
        vf = vdump;
        if (hdump == 7'(video_pkg::h_total - 1)) begin
            hf = 7'd0;
            vf = (vdump == 7'(video_pkg::v_total - 1)) ? 7'd0 : vdump + 7'd1;
        end
    end

    assign sx    = hdump[5:0] + scroll;
    assign sx_f  = hf[5:0] + scroll;
    // New tile boundary, or the partial tile at the left edge
    assign fetch = hf < video_pkg::h_visible && (sx_f[2:0] == 3'd0 || hf == 7'd0);

    cpu_ram #(
        .entry_t ( video_pkg::tile_entry_t  ),
        .depth   ( cpu_bus_pkg::map_entries )
    ) u_map (
        .clk      ( clk                  ),
        .rst_n    ( rst_n                ),
        .vid_rd   ( fetch                ),
        .vid_addr ( {vf[5:3], sx_f[5:3]} ),
        .vid_data ( ent                  ),
        .req      ( req                  ),
        .valid    ( map_valid            ),
        .ready    ( map_ready            ),
        .rdata    ( map_rdata            ),
        .rvalid   ( map_rvalid           )
    );

    // Left pixel sits in the high bits of the even byte
    assign pat_row = {pat_rom[{ent.code, vdump[2:0], 1'b0}],
                      pat_rom[{ent.code, vdump[2:0], 1'b1}]};

    // Load skips pixels already scrolled past, then shift one pixel per clock
    always_ff @(posedge clk) begin
        if (ld_q) begin
            shift    <= pat_row << {sx[2:0], 1'b0};
            cur_bank <= ent.bank;
            cur_prio <= ent.prio;
        end else begin
            shift <= shift << 2;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (enable) begin
            pxl <= '{prio: cur_prio, bank: cur_bank, color: shift[15:14]};
        end else begin
            pxl <= '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/obj_layer.sv
// Object layer: sprite RAM, shape PROM, line selection in hblank and per-pixel output
`timescale 1ns/10ps
`default_nettype none

module obj_layer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [6:0]              hdump,
    input  logic [6:0]              vdump,
    input  logic                    lhbl,
    input  cpu_bus_pkg::cpu_req_t   req,
    input  logic                    valid,
    output logic                    ready,
    output logic [15:0]             rdata,
    output logic                    rvalid,
    input  cpu_bus_pkg::prog_t      prog,
    input  logic                    enable,
    output video_pkg::layer_pxl_t   pxl
);

    // One selected object for the current line
    typedef struct packed {
        logic        act;
        logic [5:0]  x;
        logic [1:0]  bank;
        logic [15:0] row;
    } slot_t;

    logic [7:0]             shape_rom [64];
    slot_t                  slots [cpu_bus_pkg::obj_entries];
    logic [6:0]             fetch_n;
    logic                   vid_rd;
    logic                   rd_v_q;
    logic [1:0]             rd_idx_q;
    video_pkg::obj_entry_t  ent;
    logic [6:0]             nl;
    logic [6:0]             dy;
    logic                   hit;
    logic [15:0]            shp_row;
    logic [6:0]             dx;
    logic [1:0]             col;
    logic [1:0]             win_col;
    logic [1:0]             win_bank;
    video_pkg::layer_pxl_t  s1;

    function automatic logic [1:0] pick(input logic [15:0] row, input logic [2:0] p);
        return row[{~p, 1'b1} -: 2];
    endfunction

    // Read the entries during the first clocks of hblank
    assign fetch_n = hdump - 7'(video_pkg::h_visible);
    assign vid_rd  = !lhbl && fetch_n < 7'(cpu_bus_pkg::obj_entries);

    cpu_ram #(
        .entry_t ( video_pkg::obj_entry_t   ),
        .depth   ( cpu_bus_pkg::obj_entries )
    ) u_objram (
        .clk      ( clk          ),
        .rst_n    ( rst_n        ),
        .vid_rd   ( vid_rd       ),
        .vid_addr ( fetch_n[1:0] ),
        .vid_data ( ent          ),
        .req      ( req          ),
        .valid    ( valid        ),
        .ready    ( ready        ),
        .rdata    ( rdata        ),
        .rvalid   ( rvalid       )
    );

    always_ff @(posedge clk) begin
        if (prog.en && prog.addr[10:8] == cpu_bus_pkg::region_obj) begin
            shape_rom[prog.addr[5:0]] <= prog.data;
        end
    end

    // Objects are selected for the line that follows
    assign nl      = (vdump == 7'(video_pkg::v_total - 1)) ? 7'd0 : vdump + 7'd1;
    assign dy      = nl - {1'b0, ent.y};
    assign hit     = dy < 7'd8;
    assign shp_row = {shape_rom[{ent.shape, dy[2:0], 1'b0}],
                      shape_rom[{ent.shape, dy[2:0], 1'b1}]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_v_q   <= 1'b0;
            rd_idx_q <= 2'd0;
            for (int i = 0; i < cpu_bus_pkg::obj_entries; i++) begin
                slots[i] <= '0;
            end
        end else begin
            rd_v_q   <= vid_rd;
            rd_idx_q <= fetch_n[1:0];
            if (rd_v_q) begin
                slots[rd_idx_q] <= '{act: hit, x: ent.x, bank: ent.bank, row: shp_row};
            end
        end
    end

    // Scan from the highest index so object 0 ends up on top
    always_comb begin
        win_col  = 2'd0;
        win_bank = 2'd0;
        dx       = 7'd0;
        col      = 2'd0;
        for (int i = cpu_bus_pkg::obj_entries - 1; i >= 0; i--) begin
            dx  = hdump - {1'b0, slots[i].x};
            col = pick(slots[i].row, dx[2:0]);
            if (slots[i].act && dx < 7'd8 && col != 2'd0) begin
                win_col  = col;
                win_bank = slots[i].bank;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1  <= '0;
            pxl <= '0;
        end else begin
            s1  <= '{prio: 1'b0, bank: win_bank, color: win_col};
            pxl <= enable ? s1 : '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/color_mixer.sv
// Layer priority, palette PROM lookup and final blanking of the color output
`timescale 1ns/10ps
`default_nettype none

module color_mixer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    lhbl,
    input  logic                    lvbl,
    input  video_pkg::layer_pxl_t   tile_pxl,
    input  video_pkg::layer_pxl_t   obj_pxl,
    input  cpu_bus_pkg::prog_t      prog,
    output video_pkg::rgb_t         rgb,
    output logic                    lhbl_dly,
    output logic                    lvbl_dly
);

    // Red, green and blue nibble PROMs, indexed by region
    logic [3:0]       pal [3][32];
    logic             obj_show;
    logic [4:0]       pal_idx;
    video_pkg::rgb_t  pal_rgb;

    always_ff @(posedge clk) begin
        if (prog.en && prog.addr[10:8] <= cpu_bus_pkg::region_blue) begin
            pal[prog.addr[9:8]][prog.addr[4:0]] <= prog.data[3:0];
        end
    end

    // Tile with prio and a visible pixel hides the objects
    assign obj_show = obj_pxl.color != 2'd0 &&
                      !(tile_pxl.prio && tile_pxl.color != 2'd0);

    always_comb begin
        if (obj_show) begin
            pal_idx = {1'b1, obj_pxl.bank, obj_pxl.color};
        end else if (tile_pxl.color != 2'd0) begin
            pal_idx = {1'b0, tile_pxl.bank, tile_pxl.color};
        end else begin
            pal_idx = 5'd0;
        end
    end

    assign pal_rgb = '{red:   pal[0][pal_idx],
                       green: pal[1][pal_idx],
                       blue:  pal[2][pal_idx]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb      <= '0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
        end else begin
            rgb      <= (lhbl && lvbl) ? pal_rgb : '0;
            lhbl_dly <= lhbl;
            lvbl_dly <= lvbl;
        end
    end

endmodule

`default_nettype wire

//--- hw/tilevid.sv
// Top level of the tile and sprite video subsystem, connecting timer, layers and mixer
`timescale 1ns/10ps
`default_nettype none

module tilevid (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cpu_bus_pkg::cpu_req_t   cpu_req,
    input  logic                    vram_valid,
    output logic                    vram_ready,
    output logic [15:0]             vram_rdata,
    output logic                    vram_rvalid,
    input  logic                    obj_valid,
    output logic                    obj_ready,
    output logic [15:0]             obj_rdata,
    output logic                    obj_rvalid,
    input  cpu_bus_pkg::prog_t      prog,
    input  logic [1:0]              layer_en,
    output video_pkg::rgb_t         rgb,
    output logic                    hs,
    output logic                    vs,
    output logic                    lhbl_dly,
    output logic                    lvbl_dly
);

    logic [6:0]             hdump;
    logic [6:0]             vdump;
    logic                   lhbl;
    logic                   lhbl_d2;
    logic                   lvbl_d2;
    video_pkg::layer_pxl_t  tile_pxl;
    video_pkg::layer_pxl_t  obj_pxl;

    // Raw vertical blank is only needed through its delayed copy
    video_timer u_timer (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .hdump   ( hdump   ),
        .vdump   ( vdump   ),
        .lhbl    ( lhbl    ),
        .lvbl    (         ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .lhbl_d2 ( lhbl_d2 ),
        .lvbl_d2 ( lvbl_d2 )
    );

    tile_layer u_tile (
        .clk    ( clk         ),
        .rst_n  ( rst_n       ),
        .hdump  ( hdump       ),
        .vdump  ( vdump       ),
        .req    ( cpu_req     ),
        .valid  ( vram_valid  ),
        .ready  ( vram_ready  ),
        .rdata  ( vram_rdata  ),
        .rvalid ( vram_rvalid ),
        .prog   ( prog        ),
        .enable ( layer_en[0] ),
        .pxl    ( tile_pxl    )
    );

    obj_layer u_obj (
        .clk    ( clk         ),
        .rst_n  ( rst_n       ),
        .hdump  ( hdump       ),
        .vdump  ( vdump       ),
        .lhbl   ( lhbl        ),
        .req    ( cpu_req     ),
        .valid  ( obj_valid   ),
        .ready  ( obj_ready   ),
        .rdata  ( obj_rdata   ),
        .rvalid ( obj_rvalid  ),
        .prog   ( prog        ),
        .enable ( layer_en[1] ),
        .pxl    ( obj_pxl     )
    );

    color_mixer u_colmix (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .lhbl     ( lhbl_d2  ),
        .lvbl     ( lvbl_d2  ),
        .tile_pxl ( tile_pxl ),
        .obj_pxl  ( obj_pxl  ),
        .prog     ( prog     ),
        .rgb      ( rgb      ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly )
    );

endmodule

`default_nettype wire

//--- test/clk_gen.sv
// Free-running testbench clock, period set by parameter and instantiated once by the testbench
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
    parameter real period_ns = 40.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- test/tb_video.sv
// Testbench for tilevid that loads the PROMs, runs CPU traffic and checks whole frames
`timescale 1ns/10ps
`default_nettype none

module tb_video;

    localparam int frame_cycles = 96 * 80;
    localparam int prom_bytes   = 3 * 32 + 256 + 64;
    localparam int cpu_ops      = 200;
    // Reset, PROM download and CPU traffic with each access bounded at 10 clocks
    localparam int load_cycles  = 16 + prom_bytes + (cpu_ops + 69) * 10;
    localparam int frames_run   = 4;
    // One extra frame to line up with vertical blanking plus some slack
    localparam int margin       = frame_cycles + 1000;
    localparam int timeout_cycles = load_cycles + frames_run * frame_cycles + margin;

    logic                   clk;
    logic                   rst_n;
    cpu_bus_pkg::cpu_req_t  cpu_req;
    logic                   vram_valid;
    logic                   vram_ready;
    logic [15:0]            vram_rdata;
    logic                   vram_rvalid;
    logic                   obj_valid;
    logic                   obj_ready;
    logic [15:0]            obj_rdata;
    logic                   obj_rvalid;
    cpu_bus_pkg::prog_t     prog;
    logic [1:0]             layer_en;
    video_pkg::rgb_t        rgb;
    logic                   hs;
    logic                   vs;
    logic                   lhbl_dly;
    logic                   lvbl_dly;

    // Model copies of everything loaded into the DUT
    logic [3:0]   pal_r [32];
    logic [3:0]   pal_g [32];
    logic [3:0]   pal_b [32];
    logic [7:0]   pat [256];
    logic [7:0]   shp [64];
    logic [15:0]  map_m [64];
    logic [15:0]  obj_m [4];
    logic [5:0]   scroll_m;
    logic [1:0]   en_m;
    logic [31:0]  rng_state;

    int   pix_cnt;
    int   line_cnt;
    int   hs_low;
    int   vs_low;
    int   checked;
    int   cycle_cnt;
    int   vram_stalls;
    int   obj_stalls;
    logic prev_lhbl;
    logic prev_lvbl;
    logic prev_hs;
    logic prev_vs;
    logic check_en;

    clk_gen #(.period_ns(40.0)) u_clk (.clk(clk));

    tilevid dut (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .cpu_req     ( cpu_req     ),
        .vram_valid  ( vram_valid  ),
        .vram_ready  ( vram_ready  ),
        .vram_rdata  ( vram_rdata  ),
        .vram_rvalid ( vram_rvalid ),
        .obj_valid   ( obj_valid   ),
        .obj_ready   ( obj_ready   ),
        .obj_rdata   ( obj_rdata   ),
        .obj_rvalid  ( obj_rvalid  ),
        .prog        ( prog        ),
        .layer_en    ( layer_en    ),
        .rgb         ( rgb         ),
        .hs          ( hs          ),
        .vs          ( vs          ),
        .lhbl_dly    ( lhbl_dly    ),
        .lvbl_dly    ( lvbl_dly    )
    );

    function automatic logic [15:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[30:15];
    endfunction

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    // Color of one visible pixel from the layer, priority and palette rules
    function automatic logic [11:0] expected_rgb(input int x, input int y);
        int          sx;
        int          dx;
        int          dy;
        logic [15:0] ent;
        logic [15:0] row;
        logic [1:0]  t_col;
        logic [1:0]  o_col;
        logic [1:0]  o_bank;
        logic [1:0]  c;
        logic        t_prio;
        logic        o_hit;
        logic [4:0]  idx;
        sx     = (x + scroll_m) % 64;
        ent    = map_m[(y / 8) * 8 + sx / 8];
        row    = {pat[ent[3:0] * 16 + (y % 8) * 2], pat[ent[3:0] * 16 + (y % 8) * 2 + 1]};
        t_col  = en_m[0] ? row[15 - 2 * (sx % 8) -: 2] : 2'd0;
        t_prio = en_m[0] & ent[6];
        o_hit  = 1'b0;
        o_col  = 2'd0;
        o_bank = 2'd0;
        // Lowest-numbered object with a visible pixel wins
        for (int i = 0; i < 4; i++) begin
            dx = x - int'(obj_m[i][5:0]);
            dy = y - int'(obj_m[i][11:6]);
            if (en_m[1] && !o_hit && dx >= 0 && dx < 8 && dy >= 0 && dy < 8) begin
                row = {shp[obj_m[i][13:12] * 16 + dy * 2],
                       shp[obj_m[i][13:12] * 16 + dy * 2 + 1]};
                c   = row[15 - 2 * dx -: 2];
                if (c != 2'd0) begin
                    o_hit  = 1'b1;
                    o_col  = c;
                    o_bank = obj_m[i][15:14];
                end
            end
        end
        if (o_hit && !(t_prio && t_col != 2'd0)) begin
            idx = {1'b1, o_bank, o_col};
        end else if (t_col != 2'd0) begin
            idx = {1'b0, ent[5:4], t_col};
        end else begin
            idx = 5'd0;
        end
        return {pal_r[idx], pal_g[idx], pal_b[idx]};
    endfunction

    task automatic prom_write(input logic [10:0] addr, input logic [7:0] data);
        @(posedge clk);
        prog.addr <= addr;
        prog.data <= data;
        prog.en   <= 1'b1;
    endtask

    // One CPU access that is held while the layer is busy with video fetches
    task automatic cpu_access(input logic obj_side, input logic [6:0] addr, input logic we,
                              input logic [15:0] wdata, output logic [15:0] rd);
        @(posedge clk);
        cpu_req.addr  <= addr;
        cpu_req.wdata <= wdata;
        cpu_req.we    <= we;
        if (obj_side) begin
            obj_valid <= 1'b1;
        end else begin
            vram_valid <= 1'b1;
        end
        @(negedge clk);
        while (obj_side ? !obj_ready : !vram_ready) begin
            if (obj_side) begin
                obj_stalls++;
            end else begin
                vram_stalls++;
            end
            @(negedge clk);
        end
        @(posedge clk);
        obj_valid  <= 1'b0;
        vram_valid <= 1'b0;
        @(negedge clk);
        if (obj_side) begin
            rd = obj_rdata;
            compare_value("obj_rvalid", obj_rvalid, !we);
        end else begin
            rd = vram_rdata;
            compare_value("vram_rvalid", vram_rvalid, !we);
        end
    endtask

    task automatic write_scene(input logic park_objs);
        logic [15:0] rd;
        int          bx;
        int          by;
        bx = 8 + lcg_next() % 40;
        by = 8 + lcg_next() % 40;
        for (int i = 0; i < 64; i++) begin
            map_m[i] = lcg_next();
            cpu_access(1'b0, 7'(i), 1'b1, map_m[i], rd);
        end
        scroll_m = 6'(lcg_next());
        cpu_access(1'b0, 7'd64, 1'b1, {10'd0, scroll_m}, rd);
        // Objects clustered so they overlap, or parked in the bottom right corner
        for (int i = 0; i < 4; i++) begin
            if (park_objs) begin
                obj_m[i] = {2'd0, 2'd0, 6'd63, 6'd63};
            end else begin
                obj_m[i] = {2'(lcg_next()), 2'(lcg_next()),
                            6'(by + lcg_next() % 4), 6'(bx + lcg_next() % 4)};
            end
            cpu_access(1'b1, 7'(i), 1'b1, obj_m[i], rd);
        end
    endtask

    // Starts in vertical blanking, checks one frame, returns at the next blanking
    task automatic check_one_frame();
        checked  = 0;
        check_en = 1'b1;
        do @(negedge clk); while (!lvbl_dly);
        do @(negedge clk); while (lvbl_dly);
        check_en = 1'b0;
        compare_value("pixels checked per frame", checked, 64 * 64);
    endtask

    // Pixel position from blanking edges, rgb compare and timing counts
    always @(negedge clk) begin
        if (rst_n) begin
            if (lvbl_dly && !prev_lvbl) begin
                line_cnt = 0;
            end
            if (lhbl_dly && !prev_lhbl) begin
                pix_cnt = 0;
                if (lvbl_dly) begin
                    line_cnt++;
                end
            end
            if (lhbl_dly && lvbl_dly) begin
                if (check_en) begin
                    compare_value($sformatf("rgb at x=%0d y=%0d", pix_cnt, line_cnt - 1),
                                  rgb, expected_rgb(pix_cnt, line_cnt - 1));
                    checked++;
                end
            end else begin
                compare_value("rgb in blanking", rgb, 0);
            end
            if (lhbl_dly) begin
                pix_cnt++;
            end
            if (!lhbl_dly && prev_lhbl) begin
                compare_value("lhbl_dly high cycles per line", pix_cnt, 64);
            end
            if (!lvbl_dly && prev_lvbl) begin
                compare_value("lvbl_dly high lines per frame", line_cnt, 64);
            end
            if (!hs) begin
                hs_low++;
            end
            if (hs && !prev_hs) begin
                compare_value("hs low cycles", hs_low, 8);
                hs_low = 0;
            end
            // Vertical sync spans three whole lines
            if (!vs) begin
                vs_low++;
            end
            if (vs && !prev_vs) begin
                compare_value("vs low cycles", vs_low, 3 * 96);
                vs_low = 0;
            end
            prev_lhbl = lhbl_dly;
            prev_lvbl = lvbl_dly;
            prev_hs   = hs;
            prev_vs   = vs;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
            stop_run();
        end
    end

    initial begin
        logic [15:0] rd;
        logic [15:0] w;
        logic [15:0] r;
        logic [6:0]  a;
        rng_state   = 32'd58;
        rst_n       = 1'b0;
        cpu_req     = '0;
        vram_valid  = 1'b0;
        obj_valid   = 1'b0;
        prog        = '0;
        layer_en    = 2'b11;
        en_m        = 2'b11;
        check_en    = 1'b0;
        pix_cnt     = 0;
        line_cnt    = 0;
        hs_low      = 0;
        vs_low      = 0;
        checked     = 0;
        cycle_cnt   = 0;
        vram_stalls = 0;
        obj_stalls  = 0;
        prev_lhbl   = 1'b0;
        prev_lvbl   = 1'b0;
        prev_hs     = 1'b1;
        prev_vs     = 1'b1;

        // Outputs in their reset state while reset is still held
        repeat (15) @(posedge clk);
        @(negedge clk);
        compare_value("rgb", rgb, 0);
        compare_value("lhbl_dly", lhbl_dly, 0);
        compare_value("lvbl_dly", lvbl_dly, 0);
        compare_value("hs", hs, 1);
        compare_value("vs", vs, 1);
        compare_value("vram_ready", vram_ready, 1);
        compare_value("obj_ready", obj_ready, 1);
        compare_value("vram_rvalid", vram_rvalid, 0);
        compare_value("obj_rvalid", obj_rvalid, 0);
        @(posedge clk);
        rst_n <= 1'b1;

        // PROM download of palette nibbles, tile patterns and object shapes
        for (int i = 0; i < 32; i++) begin
            pal_r[i] = 4'(lcg_next());
            pal_g[i] = 4'(lcg_next());
            pal_b[i] = 4'(lcg_next());
            prom_write({3'd0, 8'(i)}, {4'd0, pal_r[i]});
            prom_write({3'd1, 8'(i)}, {4'd0, pal_g[i]});
            prom_write({3'd2, 8'(i)}, {4'd0, pal_b[i]});
        end
        for (int i = 0; i < 256; i++) begin
            pat[i] = 8'(lcg_next());
            prom_write({3'd3, 8'(i)}, pat[i]);
        end
        for (int i = 0; i < 64; i++) begin
            shp[i] = 8'(lcg_next());
            prom_write({3'd4, 8'(i)}, shp[i]);
        end
        @(posedge clk);
        prog.en <= 1'b0;

        // Fill both RAMs, then random reads and writes while video is running
        write_scene(1'b0);
        for (int i = 0; i < cpu_ops; i++) begin
            w = lcg_next();
            r = lcg_next();
            repeat (r[3:2]) @(posedge clk);
            if (r[0]) begin
                a = 7'(r[9:8]);
                cpu_access(1'b1, a, r[1], w, rd);
                if (r[1]) begin
                    obj_m[a] = w;
                end else begin
                    compare_value("obj_rdata", rd, obj_m[a]);
                end
            end else begin
                a = 7'(r[15:8] % 65);
                cpu_access(1'b0, a, r[1], w, rd);
                if (r[1] && a == 7'd64) begin
                    scroll_m = w[5:0];
                end else if (r[1]) begin
                    map_m[a] = w;
                end else if (a == 7'd64) begin
                    compare_value("vram_rdata", rd, {10'd0, scroll_m});
                end else begin
                    compare_value("vram_rdata", rd, map_m[a]);
                end
            end
        end
        if (vram_stalls == 0) begin
            $display("Tile map requests never had to wait for a video fetch");
            stop_run();
        end
        if (obj_stalls == 0) begin
            $display("Object RAM requests never had to wait for a video fetch");
            stop_run();
        end

        // Line up with vertical blanking, then one scene per frame
        do @(negedge clk); while (!lvbl_dly);
        do @(negedge clk); while (lvbl_dly);
        write_scene(1'b1);
        check_one_frame();
        write_scene(1'b0);
        check_one_frame();
        @(posedge clk);
        layer_en <= 2'b10;
        en_m = 2'b10;
        check_one_frame();
        @(posedge clk);
        layer_en <= 2'b01;
        en_m = 2'b01;
        check_one_frame();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tilevid.f
hw/video_pkg.sv
hw/cpu_bus_pkg.sv
hw/cpu_ram.sv
hw/video_timer.sv
hw/tile_layer.sv
hw/obj_layer.sv
hw/color_mixer.sv
hw/tilevid.sv
test/clk_gen.sv
test/tb_video.sv
